//--- icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_NUM_SETS    8
`define ICACHE_NUM_WAYS    4    // ways per set
`define ICACHE_BLOCK_WORDS 4    // words per block

// instruction word width
`define ICACHE_WORD_BITS   32

`endif

//--- icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    // address split: byte bits, word offset, set index, tag
    localparam int OFF_LSB = 2;
    localparam int SET_LSB = OFF_LSB + $clog2(`ICACHE_BLOCK_WORDS);
    localparam int TAG_LSB = SET_LSB + $clog2(`ICACHE_NUM_SETS);

    typedef logic [31:0]                           addr_t;
    typedef logic [`ICACHE_WORD_BITS-1:0]          word_t;
    typedef logic [$clog2(`ICACHE_NUM_SETS)-1:0]    set_idx_t;
    typedef logic [$clog2(`ICACHE_NUM_WAYS)-1:0]    way_idx_t;
    typedef logic [$clog2(`ICACHE_BLOCK_WORDS)-1:0] word_off_t;
    typedef logic [31-TAG_LSB:0]                   tag_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        RESPOND
    } ctrl_state_t;

endpackage

//--- icache_tag_store.sv
`include "icache_cfg.svh"

module icache_tag_store import icache_pkg::*; (
    input  logic     Clk,
    input  logic     reset,
    input  set_idx_t lookup_set,
    input  tag_t     lookup_tag,
    input  logic     tag_write,
    input  way_idx_t write_way,
    output logic     hit,
    output way_idx_t hit_way,
    output way_idx_t victim_way
);

    tag_t                       tags   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    logic [`ICACHE_NUM_WAYS-1:0] valid  [`ICACHE_NUM_SETS];
    way_idx_t                   rr_ptr [`ICACHE_NUM_SETS];  // next victim once the set is full
    way_idx_t                   next_ptr;

    // parallel compare over all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (valid[lookup_set][w] && (tags[lookup_set][w] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    // lowest invalid way wins, otherwise the round-robin pointer
    always_comb begin
        victim_way = rr_ptr[lookup_set];
        for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[lookup_set][w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    // way after the one just written, wrapping at the last way
    assign next_ptr = (write_way == way_idx_t'(`ICACHE_NUM_WAYS - 1)) ? '0 : write_way + 1'b1;

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (tag_write) begin
            valid[lookup_set][write_way] <= 1'b1;
            rr_ptr[lookup_set]           <= next_ptr;
        end
    end

    always_ff @(posedge Clk) begin
        if (tag_write) begin
            tags[lookup_set][write_way] <= lookup_tag;  // only meaningful once valid
        end
    end

endmodule

//--- icache_data_store.sv
`include "icache_cfg.svh"

module icache_data_store import icache_pkg::*; (
    input  logic                         Clk,
    input  set_idx_t                     read_set,
    input  word_off_t                    read_offset,
    input  logic                         fill_en,
    input  set_idx_t                     fill_set,
    input  way_idx_t                     fill_way,
    input  word_off_t                    fill_offset,
    input  word_t                        fill_word,
    output word_t [`ICACHE_NUM_WAYS-1:0] way_words
);

    // block words, indexed set / way / offset
    word_t blocks [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS][`ICACHE_BLOCK_WORDS];

    // one word per cycle during a refill
    always_ff @(posedge Clk) begin
        if (fill_en) begin
            blocks[fill_set][fill_way][fill_offset] <= fill_word;
        end
    end

    // registered read of the same offset in every way
    always_ff @(posedge Clk) begin
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            way_words[w] <= blocks[read_set][w][read_offset];
        end
    end

endmodule

//--- icache_ctrl.sv
`include "icache_cfg.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                         Clk,
    input  logic                         reset,
    input  logic                         read_enable,
    input  addr_t                        read_address,
    input  logic                         hit,
    input  way_idx_t                     hit_way,
    input  way_idx_t                     victim_way,
    input  word_t [`ICACHE_NUM_WAYS-1:0] way_words,
    input  word_t                        mem_data_in,
    input  logic                         mem_data_ready,
    output word_t                        instruction,
    output logic                         ready,
    output logic                         busy,
    output addr_t                        mem_read_address,
    output logic                         mem_read_request,
    output set_idx_t                     req_set,
    output tag_t                         req_tag,
    output word_off_t                    req_offset,
    output logic                         tag_write,
    output way_idx_t                     write_way,
    output logic                         fill_en,
    output set_idx_t                     fill_set,
    output way_idx_t                     fill_way,
    output word_off_t                    fill_offset,
    output word_t                        fill_word
);

    ctrl_state_t state;
    logic        accept;
    logic        last_word;
    word_off_t   fill_cnt;   // next refill word expected
    set_idx_t    set_q;
    tag_t        tag_q;
    word_off_t   off_q;
    way_idx_t    victim_q;   // way being refilled

    assign busy             = (state == LOOKUP) || (state == FILL);
    assign ready            = (state == RESPOND);   // RESPOND lasts exactly one cycle
    assign mem_read_request = (state == FILL);
    assign accept           = read_enable && !busy;

    // stores see the incoming address while idle so the data read lands at accept
    assign req_set    = busy ? set_q : read_address[SET_LSB +: $bits(set_idx_t)];
    assign req_tag    = busy ? tag_q : read_address[TAG_LSB +: $bits(tag_t)];
    assign req_offset = busy ? off_q : read_address[OFF_LSB +: $bits(word_off_t)];

    assign mem_read_address = {tag_q, set_q, {SET_LSB{1'b0}}};  // block aligned

    assign last_word   = (fill_cnt == word_off_t'(`ICACHE_BLOCK_WORDS - 1));
    assign fill_en     = (state == FILL) && mem_data_ready;
    assign fill_set    = set_q;
    assign fill_way    = victim_q;
    assign fill_offset = fill_cnt;
    assign fill_word   = mem_data_in;
    assign tag_write   = fill_en && last_word;  // block complete
    assign write_way   = victim_q;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state    <= IDLE;
            fill_cnt <= '0;
        end else begin
            case (state)
                IDLE, RESPOND: begin
                    state <= accept ? LOOKUP : IDLE;
                end
                LOOKUP: begin
                    state    <= hit ? RESPOND : FILL;
                    fill_cnt <= '0;
                end
                FILL: begin
                    if (fill_en) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (last_word) begin
                            state <= RESPOND;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields, victim and returned word
    always_ff @(posedge Clk) begin
        if (accept) begin
            set_q <= read_address[SET_LSB +: $bits(set_idx_t)];
            tag_q <= read_address[TAG_LSB +: $bits(tag_t)];
            off_q <= read_address[OFF_LSB +: $bits(word_off_t)];
        end
        if (state == LOOKUP) begin
            victim_q <= victim_way;
            if (hit) begin
                instruction <= way_words[hit_way];
            end
        end
        if (fill_en && (fill_cnt == off_q)) begin
            instruction <= mem_data_in;  // requested word going by
        end
    end

endmodule

//--- icache_top.sv
`include "icache_cfg.svh"

module icache_top import icache_pkg::*; (
    input  logic  Clk,
    input  logic  reset,
    input  logic  read_enable,
    input  addr_t read_address,
    output word_t instruction,
    output logic  ready,
    output logic  busy,
    output addr_t mem_read_address,
    output logic  mem_read_request,
    input  word_t mem_data_in,
    input  logic  mem_data_ready
);

    logic                         hit;
    way_idx_t                     hit_way;
    way_idx_t                     victim_way;
    word_t [`ICACHE_NUM_WAYS-1:0] way_words;
    set_idx_t                     req_set;
    tag_t                         req_tag;
    word_off_t                    req_offset;
    logic                         tag_write;
    way_idx_t                     write_way;
    logic                         fill_en;
    set_idx_t                     fill_set;
    way_idx_t                     fill_way;
    word_off_t                    fill_offset;
    word_t                        fill_word;

    icache_ctrl u_ctrl (
        .Clk              (Clk),
        .reset            (reset),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .way_words        (way_words),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .req_set          (req_set),
        .req_tag          (req_tag),
        .req_offset       (req_offset),
        .tag_write        (tag_write),
        .write_way        (write_way),
        .fill_en          (fill_en),
        .fill_set         (fill_set),
        .fill_way         (fill_way),
        .fill_offset      (fill_offset),
        .fill_word        (fill_word)
    );

    // tags and valid bits, hit and victim choice
    icache_tag_store u_tag_store (
        .Clk        (Clk),
        .reset      (reset),
        .lookup_set (req_set),
        .lookup_tag (req_tag),
        .tag_write  (tag_write),
        .write_way  (write_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_store u_data_store (
        .Clk         (Clk),
        .read_set    (req_set),
        .read_offset (req_offset),
        .fill_en     (fill_en),
        .fill_set    (fill_set),
        .fill_way    (fill_way),
        .fill_offset (fill_offset),
        .fill_word   (fill_word),
        .way_words   (way_words)
    );

endmodule

//--- icache_checker.sv
module icache_checker import icache_pkg::*; (
    input logic  Clk,
    input logic  reset,
    input logic  busy,
    input logic  ready,
    input logic  mem_read_request,
    input addr_t mem_read_address
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // read by the testbench at the end

    // a refill only runs inside a busy access
    a_req_busy: assert property (@(posedge Clk) disable iff (reset)
        mem_read_request |-> busy)
        else begin
            $error("mem_read_request high while busy is low");
            fail_count++;
        end

    a_ready_pulse: assert property (@(posedge Clk) disable iff (reset)
        ready |=> !ready)
        else begin
            $error("ready held for more than one cycle");
            fail_count++;
        end

    // block address steady for the whole refill
    a_addr_stable: assert property (@(posedge Clk) disable iff (reset)
        mem_read_request ##1 mem_read_request |-> $stable(mem_read_address))
        else begin
            $error("mem_read_address changed during a refill");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge Clk)
        reset |=> (!mem_read_request && !ready && !busy))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

bind icache_top icache_checker u_checker (
    .Clk              (Clk),
    .reset            (reset),
    .busy             (busy),
    .ready            (ready),
    .mem_read_request (mem_read_request),
    .mem_read_address (mem_read_address)
);

//--- tb_icache.sv
`include "icache_cfg.svh"

module tb_icache import icache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD      = 40;
    localparam int NUM_ENTRIES = 16;
    localparam int RESET_AFTER = 13;   // mid-run reset follows this entry
    localparam int OFF_BITS    = $clog2(`ICACHE_BLOCK_WORDS);
    localparam int SET_BITS    = $clog2(`ICACHE_NUM_SETS);
    localparam int BLOCK_BYTES = `ICACHE_BLOCK_WORDS * 4;
    localparam int WATCHDOG_NS = (NUM_ENTRIES * 40 + 20) * PERIOD;

    logic  Clk;
    logic  reset;
    logic  read_enable;
    addr_t read_address;
    word_t instruction;
    logic  ready;
    logic  busy;
    addr_t mem_read_address;
    logic  mem_read_request;
    word_t mem_data_in;
    logic  mem_data_ready;

    int          errors;
    int          fetch_count;     // refills seen by the memory model
    time         last_beat_time;
    addr_t       expected_block;
    logic [31:0] rng = 32'd50221;

    // address, idle cycles before the request, read_enable pulse while busy
    logic [31:0] stim [NUM_ENTRIES][3] = '{
        '{32'h0000_1000, 0, 0},   // cold miss in set 0
        '{32'h0000_1004, 1, 0},   // same block hits
        '{32'h0000_1008, 0, 0},
        '{32'h0000_100C, 2, 0},
        '{32'h0000_2018, 0, 0},   // miss at offset 2
        '{32'h0000_2014, 0, 0},
        '{32'h0000_1080, 0, 0},   // set 0 fills its ways
        '{32'h0000_1100, 1, 0},
        '{32'h0000_1180, 0, 0},
        '{32'h0000_1200, 0, 0},   // evicts way 0
        '{32'h0000_1004, 0, 0},   // first block misses again
        '{32'h0000_1104, 0, 0},
        '{32'h0000_3000, 0, 1},   // stray read_enable during a miss
        '{32'h0000_3004, 0, 1},   // and during a hit
        '{32'h0000_3004, 0, 0},   // after reset this misses
        '{32'h0000_3008, 0, 0}
    };

    logic [31:0] ref_tag   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    bit          ref_valid [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    int          ref_ptr   [`ICACHE_NUM_SETS];

    icache_top u_icache_top (
        .Clk              (Clk),
        .reset            (reset),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    initial begin
        Clk = 1'b0;
        forever #(PERIOD / 2) Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        addr_t aligned;
        aligned = {a[31:2], 2'b00};
        return aligned * 32'h9E37_79B1 + 32'h1357_2468;
    endfunction

    task automatic clear_model();
        for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < `ICACHE_NUM_WAYS; w++) ref_valid[s][w] = 1'b0;
        end
    endtask

    // returns the expected hit and applies the fill on a miss
    function automatic bit predict_access(input addr_t a);
        int          s;
        int          v;
        logic [31:0] t;
        s = (a >> (2 + OFF_BITS)) % `ICACHE_NUM_SETS;
        t = a >> (2 + OFF_BITS + SET_BITS);
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) return 1'b1;
        end
        v = -1;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (!ref_valid[s][w] && v < 0) v = w;  // invalid way first
        end
        if (v < 0) v = ref_ptr[s];
        ref_tag[s][v]   = t;
        ref_valid[s][v] = 1'b1;
        ref_ptr[s]      = (v + 1) % `ICACHE_NUM_WAYS;
        return 1'b0;
    endfunction

    task automatic step();
        @(posedge Clk);
        #2;
    endtask

    // memory model with random gaps before each word
    initial begin
        int    gap;
        addr_t base;
        mem_data_ready = 1'b0;
        mem_data_in    = '0;
        fetch_count    = 0;
        last_beat_time = 0;
        forever begin
            step();
            if (mem_read_request === 1'b1) begin
                fetch_count++;
                base = mem_read_address;
                assert (base == expected_block) else begin
                    $display("FAILED t=%0t mem_read_address got %h expected %h",
                             $time, base, expected_block);
                    errors++;
                end
                for (int k = 0; k < `ICACHE_BLOCK_WORDS; k++) begin
                    rng = xorshift(rng);
                    gap = rng % 4;
                    repeat (gap) step();
                    mem_data_in    = mem_word(base + 4 * k);
                    mem_data_ready = 1'b1;
                    last_beat_time = $time;
                    step();
                    mem_data_ready = 1'b0;
                end
            end
        end
    end

    initial begin
        int    cycles;
        int    fetch_start;
        bit    exp_hit;
        bit    got_hit;
        addr_t a;
        errors       = 0;
        reset        = 1'b1;
        read_enable  = 1'b0;
        read_address = '0;
        expected_block = '0;
        clear_model();
        repeat (5) @(posedge Clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            a = stim[i][0];
            repeat (stim[i][1]) step();
            exp_hit        = predict_access(a);
            fetch_start    = fetch_count;
            expected_block = a & ~addr_t'(BLOCK_BYTES - 1);
            read_enable    = 1'b1;
            read_address   = a;
            step();  // accepting edge
            read_enable = stim[i][2][0];
            if (stim[i][2][0]) read_address = a ^ 32'h0000_0400;  // must be ignored
            step();
            cycles       = 2;
            read_enable  = 1'b0;
            read_address = a;
            while (!ready) begin
                step();
                cycles++;
            end
            got_hit = (fetch_count == fetch_start);
            assert (instruction == mem_word(a)) else begin
                $display("FAILED t=%0t instruction got %h expected %h",
                         $time, instruction, mem_word(a));
                errors++;
            end
            assert (busy == 1'b0) else begin
                $display("FAILED t=%0t busy got %0b expected 0", $time, busy);
                errors++;
            end
            assert (got_hit == exp_hit) else begin
                $display("FAILED t=%0t hit got %0b expected %0b", $time, got_hit, exp_hit);
                errors++;
            end
            assert (fetch_count - fetch_start <= 1) else begin
                $display("more than one refill started for the request at %h", a);
                errors++;
            end
            if (exp_hit) begin
                assert (cycles == 2) else begin
                    $display("FAILED t=%0t hit latency got %0d expected 2", $time, cycles);
                    errors++;
                end
            end else begin
                assert ($time == last_beat_time + PERIOD) else begin
                    $display("ready did not follow the last memory word by one cycle");
                    errors++;
                end
            end
            if (i == RESET_AFTER) begin
                step();
                reset = 1'b1;
                repeat (5) step();
                reset = 1'b0;
                clear_model();
            end
        end
        step();
        $display("errors: %0d, checker assertion failures: %0d",
                 errors, u_icache_top.u_checker.fail_count);
        if (errors == 0 && u_icache_top.u_checker.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus table finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_tag_store.sv
      - icache_data_store.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - icache_checker.sv
      - tb_icache.sv
